// File: flist.f
design/net_pkg.sv
design/cache_pkg.sv
design/req_endpoint.sv
design/link_to_cache.sv
design/tag_cache.sv
design/cache_node_top.sv
tb/tb_cache_node.sv

// File: run.sh
#!/bin/sh
# builds the memory node testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_cache_node \
  -f flist.f -o sim_cache_node || { echo "build failed"; exit 1; }
out="$(./obj_dir/sim_cache_node 2>&1)"
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -q "TEST OK" && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

// File: tb/tb_cache_node.sv
// ========================================
// memory node testbench, default parameters
// the model assumes 8 sets, 2 ways and
// 4-word blocks; responses checked in order
// ========================================
`default_nettype none

module tb_cache_node;

  localparam int sets_lp        = 8;
  localparam int ways_lp        = 2;
  localparam int words_lp       = 4;
  localparam int send_limit_lp  = 300;
  localparam int drain_limit_lp = 3000;

  logic                clk_i;
  logic                reset_i;
  logic                req_v_i;
  net_pkg::net_req_s   req_i;
  logic                req_ready_o;
  logic                resp_v_o;
  net_pkg::data_t      resp_data_o;

  // zero tags in the model match the cache after the sweep
  cache_pkg::tag_word_t m_tag [sets_lp][ways_lp];
  net_pkg::data_t       m_data [ways_lp][sets_lp][words_lp];
  int                   m_victim [sets_lp];

  // expected responses in request order
  net_pkg::data_t exp_mem [256];
  int             exp_wr;
  int             exp_rd;
  net_pkg::data_t exp_head;
  logic           exp_avail;
  logic [31:0]    lfsr_r;
  logic           stall_seen;

  cache_node_top dut0 (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .req_v_i    (req_v_i),
    .req_i      (req_i),
    .req_ready_o(req_ready_o),
    .resp_v_o   (resp_v_o),
    .resp_data_o(resp_data_o)
  );

  always #5 clk_i = ~clk_i;

  assign exp_head  = exp_mem[exp_rd[7:0]];
  assign exp_avail = (exp_rd != exp_wr);

  always @(posedge clk_i) begin
    if (!reset_i && resp_v_o) begin
      exp_rd <= exp_rd + 1;
    end
  end

  assert property (@(posedge clk_i) reset_i |=> (!req_ready_o && !resp_v_o))
    else begin
      $display("ready or response was high right after reset");
      $display("TEST FAILED");
      $fatal(1, "reset state");
    end

  assert property (@(posedge clk_i) disable iff (reset_i) resp_v_o |-> exp_avail)
    else begin
      $display("a response arrived with no request outstanding");
      $display("TEST FAILED");
      $fatal(1, "extra response");
    end

  assert property (@(posedge clk_i) disable iff (reset_i)
    (resp_v_o && exp_avail) |-> (resp_data_o == exp_head))
    else begin
      $display("[ERROR] %0t resp_data_o expected %h actual %h",
               $time, $sampled(exp_head), $sampled(resp_data_o));
      $display("TEST FAILED");
      $fatal(1, "data mismatch");
    end

  // galois form of x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function automatic logic [31:0] random_bits(int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_r = lfsr_next(lfsr_r);
      r = {r[30:0], lfsr_r[0]};
    end
    return r;
  endfunction

  function automatic net_pkg::data_t byte_merge(net_pkg::data_t old_w,
                                                net_pkg::data_t new_w,
                                                net_pkg::mask_t m);
    net_pkg::data_t res;
    res = old_w;
    for (int b = 0; b < 4; b++) begin
      if (m[b]) begin
        res[8*b +: 8] = new_w[8*b +: 8];
      end
    end
    return res;
  endfunction

  // word address with tag in 14:5, set in 4:2 and word in 1:0
  function automatic net_pkg::link_addr_t data_addr(int tag, int set, int word);
    return net_pkg::link_addr_t'(((tag << 5) | (set << 2) | word) & 32'h7fff);
  endfunction

  // tag memory address with way in bit 5 and set in 4:2
  function automatic net_pkg::link_addr_t tag_addr(int set, int way);
    return net_pkg::link_addr_t'(32'h8000 | (way << 5) | (set << 2));
  endfunction

  function automatic net_pkg::data_t model_access(net_pkg::net_req_s r);
    int             s;
    int             wd;
    int             tw;
    int             hw;
    logic [9:0]     tag;
    logic           hit;
    net_pkg::data_t res;
    s   = int'(r.addr[4:2]);
    wd  = int'(r.addr[1:0]);
    tw  = int'(r.addr[5]);
    tag = r.addr[14:5];
    hit = 1'b0;
    hw  = 0;
    res = '0;
    if (r.addr[15]) begin
      if (r.we) begin
        m_tag[s][tw] = r.data;
      end else begin
        res = m_tag[s][tw];
      end
    end else begin
      for (int w = 0; w < ways_lp; w++) begin
        if (m_tag[s][w][cache_pkg::TAG_VALID_BIT] && (m_tag[s][w][9:0] == tag)) begin
          hit = 1'b1;
          hw  = w;
        end
      end
      // a miss zero-fills the victim and loses its old block
      if (!hit) begin
        hw = m_victim[s];
        for (int i = 0; i < words_lp; i++) begin
          m_data[hw][s][i] = '0;
        end
        m_tag[s][hw] = {1'b1, 21'b0, tag};
        m_victim[s]  = (hw + 1) % ways_lp;
      end
      if (r.we) begin
        m_data[hw][s][wd] = byte_merge(m_data[hw][s][wd], r.data, r.mask);
      end else begin
        res = m_data[hw][s][wd];
      end
    end
    return res;
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TEST FAILED");
    $fatal(1, "run stopped");
  endtask

  // leaves req_v_i high so that calls can follow back to back
  task automatic send_req(input logic we, input net_pkg::mask_t mask,
                          input net_pkg::link_addr_t addr, input net_pkg::data_t data);
    net_pkg::net_req_s r;
    logic              taken;
    int                waited;
    r.we    = we;
    r.mask  = mask;
    r.addr  = addr;
    r.data  = data;
    req_v_i = 1'b1;
    req_i   = r;
    taken   = 1'b0;
    waited  = 0;
    while (!taken) begin
      // ready is registered and holds until the edge that samples it
      taken = req_ready_o;
      if (!taken) begin
        stall_seen = 1'b1;
      end
      @(posedge clk_i);
      #1;
      waited++;
      if (!taken && waited > send_limit_lp) begin
        abort_run("a request was not accepted in time");
      end
    end
    exp_mem[exp_wr[7:0]] = model_access(r);
    exp_wr++;
  endtask

  task automatic release_bus();
    req_v_i = 1'b0;
    req_i   = '0;
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (exp_rd != exp_wr) begin
      @(posedge clk_i);
      #1;
      waited++;
      if (waited > drain_limit_lp) begin
        abort_run("responses did not all arrive in time");
      end
    end
  endtask

  initial begin
    net_pkg::link_addr_t a;
    net_pkg::data_t      d;
    clk_i      = 1'b0;
    reset_i    = 1'b1;
    req_v_i    = 1'b0;
    req_i      = '0;
    lfsr_r     = 32'h6176;
    exp_wr     = 0;
    exp_rd     = 0;
    stall_seen = 1'b0;
    for (int s = 0; s < sets_lp; s++) begin
      m_victim[s] = 0;
      for (int w = 0; w < ways_lp; w++) begin
        m_tag[s][w] = '0;
        for (int i = 0; i < words_lp; i++) begin
          m_data[w][s][i] = '0;
        end
      end
    end
    repeat (3) @(posedge clk_i);
    #1;
    reset_i = 1'b0;

    // tag loads queue up behind the clear sweep
    for (int s = 0; s < sets_lp; s++) begin
      for (int w = 0; w < ways_lp; w++) begin
        send_req(1'b0, '0, tag_addr(s, w), '0);
      end
    end
    release_bus();
    wait_drain();

    // two masked stores per word, each read back
    for (int i = 0; i < 6; i++) begin
      a = data_addr(int'(random_bits(10)), int'(random_bits(3)), int'(random_bits(2)));
      send_req(1'b1, net_pkg::mask_t'(random_bits(4)), a, random_bits(32));
      send_req(1'b0, '0, a, '0);
      send_req(1'b1, net_pkg::mask_t'(random_bits(4)), a, random_bits(32));
      send_req(1'b0, '0, a, '0);
    end

    // never-touched words
    send_req(1'b0, '0, data_addr(10'h3a5, 2, 3), '0);
    send_req(1'b1, 4'hf, data_addr(10'h3a6, 2, 1), random_bits(32));

    // one tag more than there are ways, all in set 5
    for (int t = 1; t <= ways_lp + 1; t++) begin
      send_req(1'b1, 4'hf, data_addr(t, 5, 0), random_bits(32));
    end
    for (int w = 0; w < ways_lp; w++) begin
      send_req(1'b0, '0, tag_addr(5, w), '0);
    end
    send_req(1'b0, '0, data_addr(1, 5, 0), '0);
    send_req(1'b0, '0, data_addr(ways_lp + 1, 5, 0), '0);
    release_bus();
    wait_drain();

    // missing requests back to back fill the FIFO
    stall_seen = 1'b0;
    for (int i = 0; i < 10; i++) begin
      send_req(i[0], 4'hf, data_addr(10'h200 + i, i % 4, i % 4), random_bits(32));
    end
    release_bus();
    wait_drain();
    if (!stall_seen) begin
      abort_run("the request burst never met back-pressure");
    end

    // tag word written and read back through the debug path
    d = random_bits(10);
    d[cache_pkg::TAG_VALID_BIT] = 1'b1;
    send_req(1'b1, 4'hf, tag_addr(6, 1), d);
    send_req(1'b0, '0, tag_addr(6, 1), '0);
    release_bus();
    wait_drain();

    // a stray late response would still trip the assertions here
    repeat (20) @(posedge clk_i);
    if (exp_rd == exp_wr) begin
      $display("TEST OK");
      $finish;
    end else begin
      abort_run("response count does not match request count");
    end
  end

endmodule

`default_nettype wire

// File: design/cache_node_top.sv
// ========================================
// memory node top: endpoint, adapter, cache
// one response per request, in order
// ========================================
`default_nettype none

module cache_node_top #(
  parameter int sets_p        = 8,
  parameter int ways_p        = 2,
  parameter int block_words_p = 4,
  parameter int fifo_els_p    = 4
) (
  input  logic              clk_i,
  input  logic              reset_i,
  input  logic              req_v_i,
  input  net_pkg::net_req_s req_i,
  output logic              req_ready_o,
  output logic              resp_v_o,
  output net_pkg::data_t    resp_data_o
);

  // endpoint to adapter
  logic                  in_v;
  net_pkg::net_req_s     in_req;
  logic                  in_yumi;
  logic                  returning_v;
  net_pkg::data_t        returning_data;

  // adapter to cache
  logic                  cache_v;
  cache_pkg::cache_pkt_s cache_pkt;
  logic                  cache_ready;
  net_pkg::data_t        cache_data;
  logic                  cache_data_v;
  logic                  cache_yumi;

  req_endpoint #(
    .fifo_els_p(fifo_els_p)
  ) endpoint0 (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .req_v_i         (req_v_i),
    .req_i           (req_i),
    .req_ready_o     (req_ready_o),
    .in_v_o          (in_v),
    .in_req_o        (in_req),
    .in_yumi_i       (in_yumi),
    .returning_v_i   (returning_v),
    .returning_data_i(returning_data),
    .resp_v_o        (resp_v_o),
    .resp_data_o     (resp_data_o)
  );

  link_to_cache #(
    .sets_p       (sets_p),
    .ways_p       (ways_p),
    .block_words_p(block_words_p)
  ) adapter0 (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .in_v_i          (in_v),
    .in_req_i        (in_req),
    .in_yumi_o       (in_yumi),
    .cache_v_o       (cache_v),
    .cache_pkt_o     (cache_pkt),
    .cache_ready_i   (cache_ready),
    .cache_data_i    (cache_data),
    .cache_data_v_i  (cache_data_v),
    .cache_yumi_o    (cache_yumi),
    .returning_v_o   (returning_v),
    .returning_data_o(returning_data)
  );

  tag_cache #(
    .sets_p       (sets_p),
    .ways_p       (ways_p),
    .block_words_p(block_words_p)
  ) cache0 (
    .clk_i  (clk_i),
    .reset_i(reset_i),
    .v_i    (cache_v),
    .pkt_i  (cache_pkt),
    .ready_o(cache_ready),
    .v_o    (cache_data_v),
    .data_o (cache_data),
    .yumi_i (cache_yumi)
  );

endmodule

`default_nettype wire

// File: design/tag_cache.sv
// ========================================
// blocking set-associative tag cache
// one request in flight; no backing memory,
// a miss zero-fills a round-robin victim and
// its old contents are lost
// ========================================
`default_nettype none

module tag_cache #(
  parameter int sets_p        = 8,
  parameter int ways_p        = 2,
  parameter int block_words_p = 4
) (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic                  v_i,
  input  cache_pkg::cache_pkt_s pkt_i,
  output logic                  ready_o,
  output logic                  v_o,
  output net_pkg::data_t        data_o,
  input  logic                  yumi_i
);

  localparam int lg_sets_lp  = (sets_p > 1) ? $clog2(sets_p) : 1;
  localparam int lg_ways_lp  = (ways_p > 1) ? $clog2(ways_p) : 1;
  localparam int lg_words_lp = (block_words_p > 1) ? $clog2(block_words_p) : 1;
  localparam int set_lsb_lp  = cache_pkg::BYTE_OFFSET_W + lg_words_lp;
  localparam int tag_lsb_lp  = set_lsb_lp + lg_sets_lp;
  localparam int tag_w_lp    = cache_pkg::CACHE_ADDR_W - tag_lsb_lp;

  typedef logic [lg_sets_lp-1:0]  set_idx_t;
  typedef logic [lg_ways_lp-1:0]  way_idx_t;
  typedef logic [lg_words_lp-1:0] word_idx_t;
  typedef logic [tag_w_lp-1:0]    tag_t;

  typedef enum logic [1:0] {
    IDLE,
    FILL,
    RESP
  } state_e;

  state_e                state_r;
  cache_pkg::cache_pkt_s pkt_r;
  cache_pkg::cache_pkt_s cur_pkt;
  cache_pkg::tag_word_t  tag_mem_r [sets_p][ways_p];
  net_pkg::data_t        data_mem_r [ways_p][sets_p][block_words_p];
  way_idx_t              victim_r [sets_p];
  way_idx_t              fill_way_r;
  word_idx_t             fill_cnt_r;
  net_pkg::data_t        data_r;
  set_idx_t              set_idx;
  word_idx_t             word_idx;
  way_idx_t              tag_way;
  way_idx_t              hit_way;
  tag_t                  addr_tag;
  cache_pkg::tag_word_t  new_tag;
  net_pkg::data_t        old_word;
  logic                  hit;
  logic                  accept;
  logic                  is_data_op;
  logic                  fill_last;

  function automatic net_pkg::data_t merge_bytes(net_pkg::data_t old_w,
                                                 net_pkg::data_t wr_w,
                                                 net_pkg::mask_t m);
    net_pkg::data_t res;
    res = old_w;
    for (int b = 0; b < net_pkg::MASK_W; b++) begin
      if (m[b]) begin
        res[8*b +: 8] = wr_w[8*b +: 8];
      end
    end
    return res;
  endfunction

  assign ready_o = (state_r == IDLE);
  assign v_o     = (state_r == RESP);
  assign data_o  = data_r;
  assign accept  = v_i & ready_o;

  // decode the live packet while idle, the held one during a fill
  always_comb begin
    cur_pkt    = (state_r == IDLE) ? pkt_i : pkt_r;
    set_idx    = cur_pkt.addr[set_lsb_lp +: lg_sets_lp];
    word_idx   = cur_pkt.addr[cache_pkg::BYTE_OFFSET_W +: lg_words_lp];
    tag_way    = cur_pkt.addr[tag_lsb_lp +: lg_ways_lp];
    addr_tag   = cur_pkt.addr[tag_lsb_lp +: tag_w_lp];
    is_data_op = (cur_pkt.opcode == cache_pkg::LM) || (cur_pkt.opcode == cache_pkg::SM);
    fill_last  = (fill_cnt_r == word_idx_t'(block_words_p - 1));

    new_tag                           = '0;
    new_tag[cache_pkg::TAG_VALID_BIT] = 1'b1;
    new_tag[tag_w_lp-1:0]             = addr_tag;

    hit     = 1'b0;
    hit_way = '0;
    for (int w = 0; w < ways_p; w++) begin
      if (tag_mem_r[set_idx][w][cache_pkg::TAG_VALID_BIT] &&
          (tag_mem_r[set_idx][w][tag_w_lp-1:0] == addr_tag)) begin
        hit     = 1'b1;
        hit_way = way_idx_t'(w);
      end
    end
    old_word = data_mem_r[hit_way][set_idx][word_idx];
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r    <= IDLE;
      fill_cnt_r <= '0;
      for (int s = 0; s < sets_p; s++) begin
        victim_r[s] <= '0;
      end
    end else begin
      case (state_r)
        IDLE: begin
          if (accept) begin
            state_r    <= (is_data_op && !hit) ? FILL : RESP;
            fill_cnt_r <= '0;
          end
        end
        FILL: begin
          fill_cnt_r <= fill_cnt_r + 1'b1;
          if (fill_last) begin
            state_r           <= RESP;
            victim_r[set_idx] <= (fill_way_r == way_idx_t'(ways_p - 1)) ? '0
                                 : fill_way_r + 1'b1;
          end
        end
        RESP: begin
          if (yumi_i) begin
            state_r <= IDLE;
          end
        end
        default: state_r <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      pkt_r      <= pkt_i;
      fill_way_r <= victim_r[set_idx];
      case (pkt_i.opcode)
        cache_pkg::TAGST: begin
          tag_mem_r[set_idx][tag_way] <= pkt_i.data;
          data_r <= '0;
        end
        cache_pkg::TAGLA: data_r <= tag_mem_r[set_idx][tag_way];
        cache_pkg::SM: begin
          if (hit) begin
            data_mem_r[hit_way][set_idx][word_idx] <=
              merge_bytes(old_word, pkt_i.data, pkt_i.mask);
          end
          data_r <= '0;
        end
        // a load miss overwrites this at the end of the fill
        default: data_r <= old_word;
      endcase
    end

    if (state_r == FILL) begin
      data_mem_r[fill_way_r][set_idx][fill_cnt_r] <= '0;
      if (fill_last) begin
        tag_mem_r[set_idx][fill_way_r] <= new_tag;
        data_r <= '0;
        if (pkt_r.opcode == cache_pkg::SM) begin
          data_mem_r[fill_way_r][set_idx][word_idx] <=
            merge_bytes('0, pkt_r.data, pkt_r.mask);
        end
      end
    end
  end

  assert property (@(posedge clk_i) disable iff (reset_i) !(v_o && ready_o));

  // response is held until the adapter takes it
  assert property (@(posedge clk_i) disable iff (reset_i) (v_o && !yumi_i) |=> v_o);

endmodule

`default_nettype wire

// File: design/link_to_cache.sv
// ========================================
// network request to cache packet adapter
// clears every tag after reset, then serves
// the endpoint; sweep responses are dropped
// sets_p and ways_p must be powers of two
// ========================================
`default_nettype none

module link_to_cache #(
  parameter int sets_p        = 8,
  parameter int ways_p        = 2,
  parameter int block_words_p = 4
) (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic                  in_v_i,
  input  net_pkg::net_req_s     in_req_i,
  output logic                  in_yumi_o,
  output logic                  cache_v_o,
  output cache_pkg::cache_pkt_s cache_pkt_o,
  input  logic                  cache_ready_i,
  input  net_pkg::data_t        cache_data_i,
  input  logic                  cache_data_v_i,
  output logic                  cache_yumi_o,
  output logic                  returning_v_o,
  output net_pkg::data_t        returning_data_o
);

  localparam int lg_sets_lp   = (sets_p > 1) ? $clog2(sets_p) : 1;
  localparam int lg_ways_lp   = (ways_p > 1) ? $clog2(ways_p) : 1;
  localparam int lg_words_lp  = (block_words_p > 1) ? $clog2(block_words_p) : 1;
  localparam int blk_off_w_lp = lg_words_lp + cache_pkg::BYTE_OFFSET_W;
  localparam int idx_w_lp     = lg_sets_lp + lg_ways_lp;
  localparam int pad_w_lp     = cache_pkg::CACHE_ADDR_W - idx_w_lp - blk_off_w_lp;
  localparam int tags_lp      = sets_p * ways_p;

  // one extra bit so the count can reach sets_p*ways_p
  typedef logic [idx_w_lp:0] tag_cnt_t;

  typedef enum logic [1:0] {
    RESET,
    CLEAR_TAG,
    READY
  } state_e;

  state_e   state_r;
  state_e   state_n;
  tag_cnt_t sent_r;
  tag_cnt_t sent_n;
  tag_cnt_t recv_r;
  tag_cnt_t recv_n;
  logic     tag_sel;

  assign tag_sel = in_req_i.addr[net_pkg::LINK_ADDR_W-1];

  always_comb begin
    cache_v_o          = 1'b0;
    cache_pkt_o.opcode = cache_pkg::TAGST;
    cache_pkt_o.mask   = '0;
    cache_pkt_o.addr   = '0;
    cache_pkt_o.data   = '0;
    in_yumi_o          = 1'b0;
    cache_yumi_o       = 1'b0;
    returning_v_o      = 1'b0;
    returning_data_o   = cache_data_i;
    sent_n             = sent_r;
    recv_n             = recv_r;
    state_n            = state_r;

    case (state_r)
      RESET: begin
        state_n = CLEAR_TAG;
      end

      CLEAR_TAG: begin
        // low counter bits walk set first, then way
        cache_v_o        = (sent_r != tag_cnt_t'(tags_lp));
        cache_pkt_o.addr = {{pad_w_lp{1'b0}}, sent_r[idx_w_lp-1:0], {blk_off_w_lp{1'b0}}};
        cache_yumi_o     = cache_data_v_i;
        if (cache_v_o && cache_ready_i) begin
          sent_n = sent_r + 1'b1;
        end
        if (cache_data_v_i) begin
          recv_n = recv_r + 1'b1;
        end
        if ((sent_r == tag_cnt_t'(tags_lp)) && (recv_r == tag_cnt_t'(tags_lp))) begin
          state_n = READY;
        end
      end

      READY: begin
        cache_v_o = in_v_i;
        in_yumi_o = in_v_i & cache_ready_i;
        if (tag_sel) begin
          cache_pkt_o.opcode = in_req_i.we ? cache_pkg::TAGST : cache_pkg::TAGLA;
        end else begin
          cache_pkt_o.opcode = in_req_i.we ? cache_pkg::SM : cache_pkg::LM;
        end
        cache_pkt_o.mask = in_req_i.mask;
        cache_pkt_o.addr = {in_req_i.addr[net_pkg::LINK_ADDR_W-2:0],
                            {cache_pkg::BYTE_OFFSET_W{1'b0}}};
        cache_pkt_o.data = in_req_i.data;
        cache_yumi_o     = cache_data_v_i;
        returning_v_o    = cache_data_v_i;
      end

      default: begin
        state_n = RESET;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= RESET;
      sent_r  <= '0;
      recv_r  <= '0;
    end else begin
      state_r <= state_n;
      sent_r  <= sent_n;
      recv_r  <= recv_n;
    end
  end

  assert property (@(posedge clk_i) disable iff (reset_i)
    (state_r == RESET) |-> !cache_v_o);

endmodule

`default_nettype wire

// File: design/req_endpoint.sv
// ========================================
// request endpoint of a memory node
// fifo_els_p deep request queue, no credits
// responses leave one cycle after return,
// with no back-pressure
// ========================================
`default_nettype none

module req_endpoint #(
  parameter int fifo_els_p = 4
) (
  input  logic              clk_i,
  input  logic              reset_i,
  input  logic              req_v_i,
  input  net_pkg::net_req_s req_i,
  output logic              req_ready_o,
  output logic              in_v_o,
  output net_pkg::net_req_s in_req_o,
  input  logic              in_yumi_i,
  input  logic              returning_v_i,
  input  net_pkg::data_t    returning_data_i,
  output logic              resp_v_o,
  output net_pkg::data_t    resp_data_o
);

  localparam int ptr_w_lp = (fifo_els_p > 1) ? $clog2(fifo_els_p) : 1;
  localparam int cnt_w_lp = $clog2(fifo_els_p + 1);

  typedef logic [ptr_w_lp-1:0] ptr_t;
  typedef logic [cnt_w_lp-1:0] cnt_t;

  net_pkg::net_req_s fifo_mem_r [fifo_els_p];
  ptr_t wr_ptr_r;
  ptr_t rd_ptr_r;
  cnt_t count_r;
  cnt_t count_n;
  logic ready_r;
  logic push;
  logic pop;

  assign push = req_v_i & req_ready_o;
  assign pop  = in_yumi_i;

  always_comb begin
    count_n = count_r;
    if (push && !pop) begin
      count_n = count_r + 1'b1;
    end else if (pop && !push) begin
      count_n = count_r - 1'b1;
    end
  end

  // ready follows the next occupancy, so it is low out of reset
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
      count_r  <= '0;
      ready_r  <= 1'b0;
      resp_v_o <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr_r <= (wr_ptr_r == ptr_t'(fifo_els_p - 1)) ? '0 : wr_ptr_r + 1'b1;
      end
      if (pop) begin
        rd_ptr_r <= (rd_ptr_r == ptr_t'(fifo_els_p - 1)) ? '0 : rd_ptr_r + 1'b1;
      end
      count_r  <= count_n;
      ready_r  <= (count_n != cnt_t'(fifo_els_p));
      resp_v_o <= returning_v_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      fifo_mem_r[wr_ptr_r] <= req_i;
    end
    resp_data_o <= returning_data_i;
  end

  assign req_ready_o = ready_r;
  assign in_v_o      = (count_r != '0);
  assign in_req_o    = fifo_mem_r[rd_ptr_r];

  // the adapter only consumes a head that exists
  assert property (@(posedge clk_i) disable iff (reset_i) in_yumi_i |-> in_v_o);

endmodule

`default_nettype wire

// File: design/cache_pkg.sv
// ========================================
// cache packet definitions of a memory node
// byte address = low 15 bits of the network
// word address followed by 2 zero bits
// tag word: valid in bit 31, tag in low bits
// ========================================
`default_nettype none

package cache_pkg;

  localparam int BYTE_OFFSET_W = $clog2(net_pkg::MASK_W);

  // the tag-select bit of the network address is dropped
  localparam int CACHE_ADDR_W = net_pkg::LINK_ADDR_W - 1 + BYTE_OFFSET_W;

  // valid flag position inside a tag word
  localparam int TAG_VALID_BIT = 31;

  typedef enum logic [1:0] {
    LM,
    SM,
    TAGST,
    TAGLA
  } opcode_e;

  typedef logic [CACHE_ADDR_W-1:0] cache_addr_t;

  // a zero tag word means the way is invalid
  typedef logic [net_pkg::DATA_W-1:0] tag_word_t;

  // for tag ops the way index sits just above the set index
  typedef struct packed {
    opcode_e        opcode;
    net_pkg::mask_t mask;
    cache_addr_t    addr;
    net_pkg::data_t data;
  } cache_pkt_s;

endpackage

`default_nettype wire

// File: design/net_pkg.sv
// ========================================
// network-side definitions of a memory node
// data is fixed at one 32-bit word
// addresses are word addresses, bit 15 set
// selects the tag memory for debugging
// ========================================
`default_nettype none

package net_pkg;

  localparam int DATA_W      = 32;
  localparam int MASK_W      = DATA_W / 8;
  localparam int LINK_ADDR_W = 16;

  // one data word, also used as the response word
  typedef logic [DATA_W-1:0] data_t;

  // byte enables, bit i covers data[8*i +: 8]
  typedef logic [MASK_W-1:0] mask_t;

  // top bit picks tag memory over data memory
  typedef logic [LINK_ADDR_W-1:0] link_addr_t;

  // request packet as delivered by the network
  typedef struct packed {
    logic       we;
    mask_t      mask;
    link_addr_t addr;
    data_t      data;
  } net_req_s;

endpackage

`default_nettype wire
